// ==== source/spk_pkg.sv ====
`default_nettype none

package spk_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////////////

    // parameters and spike counts
    localparam int WORD_W = 32;
    // host wire words and readback bus
    localparam int HOST_W = 16;
    // host trigger vector
    localparam int TRIG_W = 16;

    // trigger bit positions
    localparam int TRIG_WINDOW  = 0;
    localparam int TRIG_MASK    = 1;
    localparam int TRIG_RESTART = 2;

    // window length in clock cycles
    localparam logic [WORD_W-1:0] WINDOW_RST = 32'd10;
    // shorter loads get raised to this
    localparam logic [WORD_W-1:0] WINDOW_MIN = 32'd2;

    // readback map above the count region
    localparam logic [7:0] ADDR_WINDOW_LO = 8'h40;
    localparam logic [7:0] ADDR_WINDOW_HI = 8'h41;
    localparam logic [7:0] ADDR_MASK      = 8'h42;

    // two host halves of one word, hi first so it lands in the msbs
    typedef struct packed {
        logic [HOST_W-1:0] hi;
        logic [HOST_W-1:0] lo;
    } spk_halves_t;

    // one word, whole or split
    typedef union packed {
        logic [WORD_W-1:0] whole;
        spk_halves_t       half;
    } spk_word_u;

endpackage

`default_nettype wire

// ==== source/spk_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module spk_ctrl #(
    parameter int NCH = 4
) (
    input  wire                         ep50trig,
    input  wire                         reset_global,
    input  wire [spk_pkg::TRIG_W-1:0]   i_trig,
    input  wire [spk_pkg::HOST_W-1:0]   i_wire_lo,
    input  wire [spk_pkg::HOST_W-1:0]   i_wire_hi,
    output logic [spk_pkg::WORD_W-1:0]  o_window_len,
    output logic [NCH-1:0]              o_chan_mask,
    output logic                        o_window_end,
    output logic                        o_clear
);

    // host word built from the two wire inputs
    spk_pkg::spk_word_u         host_word;
    // window length after the floor
    logic [spk_pkg::WORD_W-1:0] len_clamped;
    // length of the window now running
    logic [spk_pkg::WORD_W-1:0] act_len;
    // cycle position inside the window
    logic [spk_pkg::WORD_W-1:0] timer;

    ////////////////////////////////////////////////////////////////////////////
    // parameter bank
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        host_word.half.hi = i_wire_hi;
        host_word.half.lo = i_wire_lo;
    end

    // short lengths raised to the floor
    assign len_clamped = (host_word.whole < spk_pkg::WINDOW_MIN) ?
                         spk_pkg::WINDOW_MIN : host_word.whole;

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            o_window_len <= spk_pkg::WINDOW_RST;
            o_chan_mask  <= '1;
        end
        else
        begin
            // wire halves sampled in the strobe cycle
            if (i_trig[spk_pkg::TRIG_WINDOW])
                o_window_len <= len_clamped;
            if (i_trig[spk_pkg::TRIG_MASK])
                o_chan_mask <= host_word.whole[NCH-1:0];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // window timer and restart
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            timer   <= '0;
            act_len <= spk_pkg::WINDOW_RST;
            o_clear <= 1'b0;
        end
        else
        begin
            // clear follows the restart strobe by one cycle
            o_clear <= i_trig[spk_pkg::TRIG_RESTART];
            // timer held at zero through the clear cycle
            if (i_trig[spk_pkg::TRIG_RESTART] || o_clear || o_window_end)
            begin
                timer   <= '0;
                // new length picked up only at a wrap
                act_len <= o_window_len;
            end
            else
                timer <= timer + 1'b1;
        end
    end

    // last cycle of the window
    assign o_window_end = (timer == act_len - 1'b1);

    a_len_min : assert property (@(posedge ep50trig) disable iff (reset_global)
        (o_window_len >= spk_pkg::WINDOW_MIN));

    a_end_clear : assert property (@(posedge ep50trig) disable iff (reset_global)
        !(o_window_end && o_clear));

endmodule

`default_nettype wire

// ==== source/spk_counter_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module spk_counter_bank #(
    parameter int NCH = 4
) (
    input  wire                             ep50trig,
    input  wire                             reset_global,
    input  wire [NCH-1:0]                   i_spike,
    input  wire [NCH-1:0]                   i_chan_mask,
    input  wire                             i_window_end,
    input  wire                             i_clear,
    output logic [NCH*spk_pkg::WORD_W-1:0]  o_counts
);

    // cycles seen in the current window, for the rate bound
    logic [spk_pkg::WORD_W-1:0] win_tally;
    logic [spk_pkg::WORD_W-1:0] win_bound;

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
            win_tally <= '0;
        else if (i_clear || i_window_end)
            win_tally <= '0;
        else
            win_tally <= win_tally + 1'b1;
    end

    // one rise needs a high and a low cycle, so at most half plus one
    assign win_bound = ((win_tally + 1'b1) >> 1) + 1'b1;

    genvar ch;
    generate
        for (ch = 0; ch < NCH; ch++)
        begin : g_chan
            logic                       sync_1;
            logic                       sync_2;
            logic                       edge_q;
            logic                       inc;
            logic [spk_pkg::WORD_W-1:0] run_cnt;
            logic [spk_pkg::WORD_W-1:0] lat_cnt;

            // two-flop sync, then previous level for the edge
            always_ff @(posedge ep50trig)
            begin
                if (reset_global)
                begin
                    sync_1 <= 1'b0;
                    sync_2 <= 1'b0;
                    edge_q <= 1'b0;
                end
                else
                begin
                    sync_1 <= i_spike[ch];
                    sync_2 <= sync_1;
                    edge_q <= sync_2;
                end
            end

            // rising edge, dropped when masked off
            assign inc = sync_2 & ~edge_q & i_chan_mask[ch];

            always_ff @(posedge ep50trig)
            begin
                if (reset_global || i_clear)
                begin
                    run_cnt <= '0;
                    lat_cnt <= '0;
                end
                else if (i_window_end)
                begin
                    // edge in the last cycle still belongs to this window
                    lat_cnt <= run_cnt + inc;
                    run_cnt <= '0;
                end
                else
                    run_cnt <= run_cnt + inc;
            end

            assign o_counts[ch*spk_pkg::WORD_W +: spk_pkg::WORD_W] = lat_cnt;

            a_rate_bound : assert property (@(posedge ep50trig) disable iff (reset_global)
                (i_window_end && !i_clear) |=> (lat_cnt <= $past(win_bound)));
        end
    endgenerate

endmodule

`default_nettype wire

// ==== source/spk_readback.sv ====
`timescale 1ns/1ps
`default_nettype none

module spk_readback #(
    parameter int NCH = 4
) (
    input  wire                             ep50trig,
    input  wire                             reset_global,
    input  wire [7:0]                       i_rd_addr,
    input  wire [NCH*spk_pkg::WORD_W-1:0]   i_counts,
    input  wire [spk_pkg::WORD_W-1:0]       i_window_len,
    input  wire [NCH-1:0]                   i_chan_mask,
    output logic [spk_pkg::HOST_W-1:0]      o_rd_data
);

    spk_pkg::spk_word_u         len_word;
    spk_pkg::spk_word_u         cnt_word;
    logic                       cnt_hit;
    logic [spk_pkg::HOST_W-1:0] mask_ext;
    logic [spk_pkg::HOST_W-1:0] rd_next;

    ////////////////////////////////////////////////////////////////////////////
    // address decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        len_word.whole = i_window_len;
        mask_ext = '0;
        mask_ext[NCH-1:0] = i_chan_mask;
        cnt_word.whole = '0;
        cnt_hit = 1'b0;
        // counts sit at the bottom, two addresses per channel
        for (int ch = 0; ch < NCH; ch++)
        begin
            if (i_rd_addr[7:1] == 7'(ch))
            begin
                cnt_word.whole = i_counts[ch*spk_pkg::WORD_W +: spk_pkg::WORD_W];
                cnt_hit = 1'b1;
            end
        end
        if (cnt_hit)
            rd_next = i_rd_addr[0] ? cnt_word.half.hi : cnt_word.half.lo;
        else
        begin
            case (i_rd_addr)
                spk_pkg::ADDR_WINDOW_LO: rd_next = len_word.half.lo;
                spk_pkg::ADDR_WINDOW_HI: rd_next = len_word.half.hi;
                spk_pkg::ADDR_MASK:      rd_next = mask_ext;
                default:                 rd_next = '0;
            endcase
        end
    end

    // one cycle from address to data
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
            o_rd_data <= '0;
        else
            o_rd_data <= rd_next;
    end

endmodule

`default_nettype wire

// ==== source/spkcnt_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module spkcnt_top #(
    parameter int NCH = 4
) (
    input  wire                         ep50trig,
    input  wire                         reset_global,
    input  wire [spk_pkg::TRIG_W-1:0]   i_trig,
    input  wire [spk_pkg::HOST_W-1:0]   i_wire_lo,
    input  wire [spk_pkg::HOST_W-1:0]   i_wire_hi,
    input  wire [NCH-1:0]               i_spike,
    input  wire [7:0]                   i_rd_addr,
    output wire [spk_pkg::HOST_W-1:0]   o_rd_data,
    output wire                         o_window_strobe
);

    wire [spk_pkg::WORD_W-1:0]      window_len;
    wire [NCH-1:0]                  chan_mask;
    wire                            window_end;
    wire                            clear;
    wire [NCH*spk_pkg::WORD_W-1:0]  counts;

    ////////////////////////////////////////////////////////////////////////////
    // control: parameter bank and window timer
    ////////////////////////////////////////////////////////////////////////////

    spk_ctrl #(.NCH(NCH)) u_ctrl (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_trig       (i_trig),
        .i_wire_lo    (i_wire_lo),
        .i_wire_hi    (i_wire_hi),
        .o_window_len (window_len),
        .o_chan_mask  (chan_mask),
        .o_window_end (window_end),
        .o_clear      (clear)
    );

    // per-channel spike counting
    spk_counter_bank #(.NCH(NCH)) u_counters (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_spike      (i_spike),
        .i_chan_mask  (chan_mask),
        .i_window_end (window_end),
        .i_clear      (clear),
        .o_counts     (counts)
    );

    // host readback port
    spk_readback #(.NCH(NCH)) u_readback (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_rd_addr    (i_rd_addr),
        .i_counts     (counts),
        .i_window_len (window_len),
        .i_chan_mask  (chan_mask),
        .o_rd_data    (o_rd_data)
    );

    // window strobe out to the host side
    assign o_window_strobe = window_end;

endmodule

`default_nettype wire

// ==== tb/tb_spkcnt.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_spkcnt;

    localparam int NCH      = 4;
    localparam int WAIT_MAX = 400;
    localparam int LONG_LEN = 40;

    logic                       ep50trig;
    logic                       reset_global;
    logic [spk_pkg::TRIG_W-1:0] i_trig;
    logic [spk_pkg::HOST_W-1:0] i_wire_lo;
    logic [spk_pkg::HOST_W-1:0] i_wire_hi;
    logic [NCH-1:0]             i_spike;
    logic [7:0]                 i_rd_addr;
    wire  [spk_pkg::HOST_W-1:0] o_rd_data;
    wire                        o_window_strobe;

    int             seed = 32'hd652;
    int             cyc = 0;
    int             mismatches = 0;
    int             timeouts = 0;
    // per-channel pulse bookkeeping for the current window
    int             rises [NCH];
    int             high_len [NCH];
    int             low_len [NCH];
    logic [NCH-1:0] cur_mask;
    int             cur_len;

    spkcnt_top #(.NCH(NCH)) u_spkcnt_top (
        .ep50trig        (ep50trig),
        .reset_global    (reset_global),
        .i_trig          (i_trig),
        .i_wire_lo       (i_wire_lo),
        .i_wire_hi       (i_wire_hi),
        .i_spike         (i_spike),
        .i_rd_addr       (i_rd_addr),
        .o_rd_data       (o_rd_data),
        .o_window_strobe (o_window_strobe)
    );

    // 100 ns period
    initial
    begin
        ep50trig = 1'b0;
        forever
            #50 ep50trig = ~ep50trig;
    end

    // cycle stamp, read only on falling edges
    always @(posedge ep50trig)
        cyc <= cyc + 1;

    ////////////////////////////////////////////////////////////////////////////
    // reference model and helpers
    ////////////////////////////////////////////////////////////////////////////

    // masked channels count nothing
    function automatic logic [31:0] expected_count(input int n_rise,
                                                   input logic [NCH-1:0] mask, input int ch);
        if (mask[ch])
            return n_rise;
        else
            return 32'h0;
    endfunction

    function automatic bit coin_flip();
        int r;
        r = $random(seed);
        return r[0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        if (exp_val !== act_val)
        begin
            $display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, exp_val, act_val);
            mismatches++;
        end
    endtask

    // returns the cycle stamp of the strobe cycle
    task automatic wait_strobe(output int at_cyc);
        int n;
        n = 0;
        do
        begin
            @(negedge ep50trig);
            n++;
        end
        while (!o_window_strobe && n < WAIT_MAX);
        if (!o_window_strobe)
        begin
            $display("ERROR: no window strobe within %0d cycles, time %0t", WAIT_MAX, $time);
            timeouts++;
        end
        at_cyc = cyc;
    endtask

    // address in one cycle, data one cycle later
    task automatic read_half(input logic [7:0] addr, output logic [15:0] data);
        @(negedge ep50trig);
        i_rd_addr = addr;
        @(negedge ep50trig);
        data = o_rd_data;
    endtask

    // one-cycle trigger with both wire halves held
    task automatic load_param(input int bit_idx, input logic [31:0] value);
        @(negedge ep50trig);
        i_wire_lo = value[15:0];
        i_wire_hi = value[31:16];
        i_trig = '0;
        i_trig[bit_idx] = 1'b1;
        @(negedge ep50trig);
        i_trig = '0;
    endtask

    // first strobe may still use the old length, so skip it
    task automatic check_period(input int len, input string name);
        int a;
        int b;
        wait_strobe(a);
        wait_strobe(a);
        wait_strobe(b);
        check_value(name, len, b - a);
    endtask

    // pulses of 4+ cycles, rises kept clear of both window edges
    task automatic step_spike(input int ch, input int k, input int len);
        if (i_spike[ch])
        begin
            high_len[ch]++;
            if (high_len[ch] >= 4 && (coin_flip() || k >= len - 4))
            begin
                i_spike[ch] = 1'b0;
                low_len[ch] = 0;
            end
        end
        else
        begin
            low_len[ch]++;
            if (low_len[ch] >= 4 && k >= 4 && k <= len - 8 && coin_flip())
            begin
                i_spike[ch] = 1'b1;
                high_len[ch] = 0;
                rises[ch]++;
            end
        end
    endtask

    // starts on a strobe cycle, ends on the next one
    task automatic drive_window(input int len);
        int k;
        int ch;
        for (ch = 0; ch < NCH; ch++)
            rises[ch] = 0;
        k = 0;
        do
        begin
            @(negedge ep50trig);
            k++;
            if (!o_window_strobe)
            begin
                for (ch = 0; ch < NCH; ch++)
                    step_spike(ch, k, len);
            end
        end
        while (!o_window_strobe && k < WAIT_MAX);
        if (!o_window_strobe)
        begin
            $display("ERROR: window with spikes never ended, time %0t", $time);
            timeouts++;
        end
        else
            check_value("window period", len, k);
    endtask

    task automatic check_counts();
        logic [15:0] lo;
        logic [15:0] hi;
        logic [31:0] exp_val;
        int          ch;
        for (ch = 0; ch < NCH; ch++)
        begin
            exp_val = expected_count(rises[ch], cur_mask, ch);
            read_half(8'(2 * ch), lo);
            read_half(8'(2 * ch + 1), hi);
            check_value($sformatf("count[%0d] lo", ch), {16'h0, exp_val[15:0]}, {16'h0, lo});
            check_value($sformatf("count[%0d] hi", ch), {16'h0, exp_val[31:16]}, {16'h0, hi});
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        int          r;
        int          s;
        int          t0;
        logic [15:0] rd;
        reset_global = 1'b1;
        i_trig = '0;
        i_wire_lo = '0;
        i_wire_hi = '0;
        i_spike = '0;
        i_rd_addr = '0;
        cur_mask = '1;
        cur_len = 10;
        for (int ch = 0; ch < NCH; ch++)
        begin
            rises[ch] = 0;
            high_len[ch] = 0;
            low_len[ch] = 4;
        end
        repeat (8) @(negedge ep50trig);
        reset_global = 1'b0;

        // reset values
        read_half(spk_pkg::ADDR_WINDOW_LO, rd);
        check_value("window_len lo", 10, {16'h0, rd});
        read_half(spk_pkg::ADDR_WINDOW_HI, rd);
        check_value("window_len hi", 0, {16'h0, rd});
        read_half(spk_pkg::ADDR_MASK, rd);
        check_value("chan_mask", 32'hf, {16'h0, rd});
        check_counts();

        // random window length, 8 to 40
        r = $random(seed);
        cur_len = 8 + ((r & 32'h7fffffff) % 33);
        load_param(spk_pkg::TRIG_WINDOW, cur_len);
        read_half(spk_pkg::ADDR_WINDOW_LO, rd);
        check_value("window_len lo", cur_len, {16'h0, rd});
        check_period(cur_len, "window period");

        // counting, spiking windows alternate with quiet ones for readback
        cur_len = LONG_LEN;
        load_param(spk_pkg::TRIG_WINDOW, cur_len);
        wait_strobe(s);
        repeat (3)
        begin
            drive_window(cur_len);
            check_counts();
            wait_strobe(s);
        end

        // channels 1 and 3 masked off
        cur_mask = 4'b0101;
        load_param(spk_pkg::TRIG_MASK, 32'h5);
        read_half(spk_pkg::ADDR_MASK, rd);
        check_value("chan_mask", 32'h5, {16'h0, rd});
        wait_strobe(s);
        drive_window(cur_len);
        check_counts();

        // restart mid-window, counts gone before the next strobe
        @(negedge ep50trig);
        i_trig[spk_pkg::TRIG_RESTART] = 1'b1;
        t0 = cyc;
        @(negedge ep50trig);
        i_trig = '0;
        for (int ch = 0; ch < NCH; ch++)
            rises[ch] = 0;
        check_counts();
        wait_strobe(s);
        check_value("restart to strobe", cur_len + 1, s - t0);

        // too-short lengths clamp to 2
        load_param(spk_pkg::TRIG_WINDOW, 32'd0);
        read_half(spk_pkg::ADDR_WINDOW_LO, rd);
        check_value("window_len lo", 2, {16'h0, rd});
        read_half(spk_pkg::ADDR_WINDOW_HI, rd);
        check_value("window_len hi", 0, {16'h0, rd});
        check_period(2, "clamped period");
        load_param(spk_pkg::TRIG_WINDOW, 32'd1);
        read_half(spk_pkg::ADDR_WINDOW_LO, rd);
        check_value("window_len lo", 2, {16'h0, rd});
        check_period(2, "clamped period");

        $display("mismatches=%0d timeouts=%0d", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== spkcnt.f ====
source/spk_pkg.sv
source/spk_ctrl.sv
source/spk_counter_bank.sv
source/spk_readback.sv
source/spkcnt_top.sv
tb/tb_spkcnt.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the spkcnt testbench with Verilator.
# Exit status is 0 only when the simulation reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f spkcnt.f --top-module tb_spkcnt
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_spkcnt)
rc=$?
printf '%s\n' "$out"

if [ $rc -ne 0 ]; then
    echo "simulation exited with status $rc"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi

echo "simulation did not report a pass"
exit 1
